/* sim.f */
+incdir+src
src/rv_isa_pkg.sv
src/rv_pipe_pkg.sv
src/rv_fetch.sv
src/rv_decode.sv
src/rv_regfile.sv
src/rv_alu.sv
src/rv_execute.sv
src/rv_retire.sv
src/rv_pipeline.sv
dv/tb_rv_pipeline.sv

/* Bender.yml */
package:
  name: rv_pipeline

sources:
  - include_dirs:
      - src
    files:
      - src/rv_isa_pkg.sv
      - src/rv_pipe_pkg.sv
      - src/rv_fetch.sv
      - src/rv_decode.sv
      - src/rv_regfile.sv
      - src/rv_alu.sv
      - src/rv_execute.sv
      - src/rv_retire.sv
      - src/rv_pipeline.sv
  - target: test
    files:
      - dv/tb_rv_pipeline.sv

/* dv/tb_rv_pipeline.sv */
module tb_rv_pipeline;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int CLK_HALF       = 10;
  localparam int RESET_CYCLES   = 16;
  localparam int RETIRE_TARGET  = 2000;
  localparam int PROG_WORDS     = 64;
  localparam int TIMEOUT_CYCLES = RESET_CYCLES + 3 * RETIRE_TARGET + 100;

  localparam int NUM_TESTS = 5;
  localparam int T_RESET   = 0;
  localparam int T_ALU     = 1;
  localparam int T_BRANCH  = 2;
  localparam int T_X0      = 3;
  localparam int T_SEQ     = 4;

  logic                       clk;
  logic                       rst;
  rv_isa_pkg::insn_t          imem_insn = '0;
  rv_isa_pkg::word_t          imem_addr;
  rv_isa_pkg::word_t          wb_pc;
  rv_isa_pkg::insn_t          wb_insn;
  rv_pipe_pkg::cycle_status_e wb_status;
  logic                       wb_we;
  rv_isa_pkg::reg_idx_t       wb_rd;
  rv_isa_pkg::word_t          wb_data;

  logic [15:0]       lfsr;
  rv_isa_pkg::insn_t program_mem [PROG_WORDS];
  rv_isa_pkg::word_t model_regs [32];
  rv_isa_pkg::word_t model_pc;
  int                retired;
  int                pending_bubbles;
  int                cycle_count;
  int                checks [NUM_TESTS];
  int                errors [NUM_TESTS];
  string             test_names [NUM_TESTS];

  rv_pipeline DUT (
    .clk         (clk),
    .rst         (rst),
    .imem_insn_i (imem_insn),
    .imem_addr_o (imem_addr),
    .wb_pc_o     (wb_pc),
    .wb_insn_o   (wb_insn),
    .wb_status_o (wb_status),
    .wb_we_o     (wb_we),
    .wb_rd_o     (wb_rd),
    .wb_data_o   (wb_data)
  );

  initial begin
    clk = 1'b0;
    forever #CLK_HALF clk = ~clk;
  end

  // Instruction memory wraps every 64 words
  always @(negedge clk) begin
    imem_insn <= program_mem[imem_addr[7:2]];
  end

  // Taps 16, 14, 13, 11
  function automatic logic lfsr_step();
    logic feedback;
    feedback = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
    lfsr = {lfsr[14:0], feedback};
    return feedback;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] value;
    value = '0;
    for (int i = 0; i < n; i++) begin
      value = {value[30:0], lfsr_step()};
    end
    return value;
  endfunction

  function automatic rv_isa_pkg::insn_t random_insn();
    logic [2:0]  kind;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [6:0]  opcode;
    logic [11:0] imm12;
    logic [12:0] off;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    kind = 3'(rand_bits(3));
    rd   = 5'(rand_bits(3));
    rs1  = 5'(rand_bits(3));
    rs2  = 5'(rand_bits(3));
    f3   = 3'(rand_bits(3));
    if (kind == 3'd6) begin
      // 010 and 011 name no branch condition
      if (f3[2:1] == 2'b01) begin
        f3[2] = 1'b1;
      end
      // Forward only, so the wrapped program keeps flowing
      off = 13'((int'(rand_bits(5)) + 1) * 4);
      return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], rv_isa_pkg::BRANCH};
    end else if (kind == 3'd7) begin
      case (rand_bits(3))
        0:       opcode = rv_isa_pkg::LOAD;
        1:       opcode = rv_isa_pkg::STORE;
        2:       opcode = rv_isa_pkg::AUIPC;
        3:       opcode = rv_isa_pkg::JAL;
        4:       opcode = rv_isa_pkg::JALR;
        5:       opcode = rv_isa_pkg::MISC_MEM;
        6:       opcode = 7'b000_0000;
        default: opcode = rv_isa_pkg::SYSTEM;
      endcase
      return {25'(rand_bits(25)), opcode};
    end
    case (rand_bits(2))
      0: return {20'(rand_bits(20)), rd, rv_isa_pkg::LUI};
      1: begin
        imm12 = 12'(rand_bits(12));
        if (f3 == rv_isa_pkg::F3_SLL) begin
          imm12[11:5] = 7'h00;
        end else if (f3 == rv_isa_pkg::F3_SR) begin
          imm12[11:5] = rand_bits(1) ? 7'h20 : 7'h00;
        end
        return {imm12, rs1, f3, rd, rv_isa_pkg::OP_IMM};
      end
      default: begin
        f7 = 7'h00;
        if ((f3 == rv_isa_pkg::F3_ADD || f3 == rv_isa_pkg::F3_SR) && rand_bits(1)) begin
          f7 = 7'h20;
        end
        return {f7, rs2, rs1, f3, rd, rv_isa_pkg::OP};
      end
    endcase
  endfunction

  // Reference RV32I model, one instruction per call
  task automatic run_model(output logic exp_we, output rv_isa_pkg::reg_idx_t exp_rd,
                           output rv_isa_pkg::word_t exp_data, output int category,
                           output logic taken);
    rv_isa_pkg::insn_t insn;
    rv_isa_pkg::word_t a;
    rv_isa_pkg::word_t b;
    rv_isa_pkg::word_t imm_b;
    rv_isa_pkg::word_t result;
    logic [2:0]        f3;
    logic [6:0]        f7;
    logic              is_op;
    logic              alt;
    logic              valid;
    insn   = program_mem[model_pc[7:2]];
    f3     = insn[14:12];
    f7     = insn[31:25];
    alt    = f7 == 7'h20;
    is_op  = insn[6:0] == rv_isa_pkg::OP;
    a      = model_regs[insn[19:15]];
    b      = is_op ? model_regs[insn[24:20]] : {{20{insn[31]}}, insn[31:20]};
    imm_b  = {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
    valid  = 1'b0;
    taken  = 1'b0;
    result = '0;
    category = T_X0;
    case (insn[6:0])
      rv_isa_pkg::LUI: begin
        valid  = 1'b1;
        result = {insn[31:12], 12'b0};
      end
      rv_isa_pkg::OP, rv_isa_pkg::OP_IMM: begin
        if (is_op) begin
          valid = f7 == 7'h00 || (alt && (f3 == rv_isa_pkg::F3_ADD || f3 == rv_isa_pkg::F3_SR));
        end else if (f3 == rv_isa_pkg::F3_SLL) begin
          valid = f7 == 7'h00;
        end else if (f3 == rv_isa_pkg::F3_SR) begin
          valid = f7 == 7'h00 || alt;
        end else begin
          valid = 1'b1;
        end
        case (f3)
          rv_isa_pkg::F3_ADD:  result = (is_op && alt) ? a - b : a + b;
          rv_isa_pkg::F3_SLL:  result = a << b[4:0];
          rv_isa_pkg::F3_SLT:  result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
          rv_isa_pkg::F3_SLTU: result = (a < b) ? 32'd1 : 32'd0;
          rv_isa_pkg::F3_XOR:  result = a ^ b;
          rv_isa_pkg::F3_SR: begin
            if (alt) begin
              result = $signed(a) >>> b[4:0];
            end else begin
              result = a >> b[4:0];
            end
          end
          rv_isa_pkg::F3_OR:   result = a | b;
          default:             result = a & b;
        endcase
      end
      rv_isa_pkg::BRANCH: begin
        b = model_regs[insn[24:20]];
        if (f3 != 3'b010 && f3 != 3'b011) begin
          category = T_BRANCH;
        end
        case (f3)
          rv_isa_pkg::F3_BEQ:  taken = a == b;
          rv_isa_pkg::F3_BNE:  taken = a != b;
          rv_isa_pkg::F3_BLT:  taken = $signed(a) < $signed(b);
          rv_isa_pkg::F3_BGE:  taken = $signed(a) >= $signed(b);
          rv_isa_pkg::F3_BLTU: taken = a < b;
          rv_isa_pkg::F3_BGEU: taken = a >= b;
          default:             taken = 1'b0;
        endcase
      end
      default: begin
      end
    endcase
    exp_we   = valid && insn[11:7] != 5'd0;
    exp_rd   = insn[11:7];
    exp_data = result;
    if (exp_we) begin
      model_regs[insn[11:7]] = result;
      category = T_ALU;
    end
    model_pc = taken ? model_pc + imm_b : model_pc + 32'd4;
  endtask

  task automatic check_value(input int t, input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    checks[t]++;
    if (expected !== actual) begin
      errors[t]++;
      $display("Mismatch %s %s: expected %h, actual %h (wb pc %h)", test_names[t], what,
               expected, actual, wb_pc);
    end
  endtask

  task automatic report_failure(input int t, input string msg);
    errors[t]++;
    $display("Error in %s: %s", test_names[t], msg);
  endtask

  task automatic report_test(input int t);
    $display("Test %-16s %0d checks, %0d errors, %s", test_names[t], checks[t], errors[t],
             errors[t] == 0 ? "pass" : "FAIL");
  endtask

  task automatic check_writeback();
    logic                 exp_we;
    rv_isa_pkg::reg_idx_t exp_rd;
    rv_isa_pkg::word_t    exp_data;
    rv_isa_pkg::word_t    exp_pc;
    int                   category;
    logic                 taken;
    if (wb_status == rv_pipe_pkg::TAKEN_BRANCH) begin
      if (pending_bubbles == 0) begin
        report_failure(T_BRANCH, "bubble reached writeback with no taken branch ahead of it");
      end else begin
        pending_bubbles--;
      end
      check_value(T_BRANCH, "bubble pc", '0, wb_pc);
      check_value(T_BRANCH, "bubble insn", '0, wb_insn);
      check_value(T_BRANCH, "bubble we", '0, wb_we);
    end else if (wb_status == rv_pipe_pkg::NO_STALL) begin
      if (pending_bubbles != 0) begin
        report_failure(T_BRANCH, $sformatf("instruction retired with %0d bubble(s) missing",
                                           pending_bubbles));
      end
      exp_pc = model_pc;
      check_value(T_SEQ, "pc", exp_pc, wb_pc);
      check_value(T_SEQ, "insn", program_mem[exp_pc[7:2]], wb_insn);
      run_model(exp_we, exp_rd, exp_data, category, taken);
      check_value(category, "we", exp_we, wb_we);
      if (exp_we) begin
        check_value(category, "rd", exp_rd, wb_rd);
        check_value(category, "data", exp_data, wb_data);
      end
      pending_bubbles = taken ? 2 : 0;
      retired++;
    end else begin
      report_failure(T_SEQ, $sformatf("writeback status %0d where a slot was due", wb_status));
    end
  endtask

  initial begin : watchdog
    cycle_count = 0;
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("Timeout after %0d cycles with %0d of %0d instructions retired", cycle_count,
             retired, RETIRE_TARGET);
    $display("Something failed");
    $finish;
  end

  initial begin : main
    int total_errors;
    int failed_tests;
    rst             = 1'b1;
    lfsr            = 16'd53746;
    retired         = 0;
    pending_bubbles = 0;
    model_pc        = '0;
    test_names[T_RESET]  = "reset";
    test_names[T_ALU]    = "alu_results";
    test_names[T_BRANCH] = "branches";
    test_names[T_X0]     = "x0_unsupported";
    test_names[T_SEQ]    = "sequence";
    for (int t = 0; t < NUM_TESTS; t++) begin
      checks[t] = 0;
      errors[t] = 0;
    end
    for (int r = 0; r < 32; r++) begin
      model_regs[r] = '0;
    end
    for (int w = 0; w < PROG_WORDS; w++) begin
      program_mem[w] = random_insn();
    end

    // Each reset cycle ends on a rising edge that loads the reset values
    repeat (RESET_CYCLES) begin
      @(posedge clk);
      @(negedge clk);
      check_value(T_RESET, "status in reset", rv_pipe_pkg::RESET, wb_status);
      check_value(T_RESET, "we in reset", '0, wb_we);
    end
    rst = 1'b0;
    // Address zero is fetched now and needs four edges to reach writeback
    repeat (3) begin
      @(negedge clk);
      check_value(T_RESET, "status after reset", rv_pipe_pkg::RESET, wb_status);
      check_value(T_RESET, "we after reset", '0, wb_we);
      check_value(T_RESET, "pc after reset", '0, wb_pc);
    end
    @(negedge clk);
    check_value(T_RESET, "first status", rv_pipe_pkg::NO_STALL, wb_status);
    check_value(T_RESET, "first pc", '0, wb_pc);
    report_test(T_RESET);

    check_writeback();
    while (retired < RETIRE_TARGET) begin
      @(negedge clk);
      check_writeback();
    end

    total_errors = 0;
    failed_tests = 0;
    for (int t = T_ALU; t < NUM_TESTS; t++) begin
      report_test(t);
    end
    for (int t = 0; t < NUM_TESTS; t++) begin
      total_errors += errors[t];
      if (errors[t] != 0) begin
        failed_tests++;
      end
    end
    $display("Summary: %0d tests, %0d failed, %0d instructions retired, %0d errors",
             NUM_TESTS, failed_tests, retired, total_errors);
    if (total_errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

/* src/rv_pipeline.sv */
module rv_pipeline (
  input  logic                       clk,
  input  logic                       rst,
  input  rv_isa_pkg::insn_t          imem_insn_i,
  output rv_isa_pkg::word_t          imem_addr_o,
  output rv_isa_pkg::word_t          wb_pc_o,
  output rv_isa_pkg::insn_t          wb_insn_o,
  output rv_pipe_pkg::cycle_status_e wb_status_o,
  output logic                       wb_we_o,
  output rv_isa_pkg::reg_idx_t       wb_rd_o,
  output rv_isa_pkg::word_t          wb_data_o
);

  // Decode to execute
  rv_isa_pkg::word_t          d_pc;
  rv_isa_pkg::insn_t          d_insn;
  rv_isa_pkg::reg_idx_t       d_rs1;
  rv_isa_pkg::reg_idx_t       d_rs2;
  rv_isa_pkg::reg_idx_t       d_rd;
  rv_isa_pkg::word_t          d_rs1_val;
  rv_isa_pkg::word_t          d_rs2_val;
  rv_isa_pkg::word_t          d_imm;
  rv_pipe_pkg::alu_op_e       d_op;
  logic                       d_use_imm;
  logic                       d_is_branch;
  rv_isa_pkg::funct3_t        d_funct3;
  rv_pipe_pkg::cycle_status_e d_status;

  // Register file read data
  rv_isa_pkg::word_t rf_rd1;
  rv_isa_pkg::word_t rf_rd2;

  // Execute to fetch and retire
  logic                       e_redirect;
  rv_isa_pkg::word_t          e_target;
  rv_isa_pkg::word_t          e_pc;
  rv_isa_pkg::insn_t          e_insn;
  rv_isa_pkg::reg_idx_t       e_rd;
  logic                       e_we;
  rv_isa_pkg::word_t          e_result;
  rv_pipe_pkg::cycle_status_e e_status;

  // Memory stage bypass
  rv_isa_pkg::reg_idx_t m_rd;
  logic                 m_we;
  rv_isa_pkg::word_t    m_data;

  rv_fetch u_fetch (
    .clk        (clk),
    .rst        (rst),
    .redirect_i (e_redirect),
    .target_i   (e_target),
    .pc_o       (imem_addr_o)
  );

  rv_decode u_decode (
    .clk         (clk),
    .rst         (rst),
    .squash_i    (e_redirect),
    .pc_i        (imem_addr_o),
    .insn_i      (imem_insn_i),
    .rs1_data_i  (rf_rd1),
    .rs2_data_i  (rf_rd2),
    .pc_o        (d_pc),
    .insn_o      (d_insn),
    .rs1_o       (d_rs1),
    .rs2_o       (d_rs2),
    .rd_o        (d_rd),
    .rs1_val_o   (d_rs1_val),
    .rs2_val_o   (d_rs2_val),
    .imm_o       (d_imm),
    .op_o        (d_op),
    .use_imm_o   (d_use_imm),
    .is_branch_o (d_is_branch),
    .funct3_o    (d_funct3),
    .status_o    (d_status)
  );

  rv_regfile u_regfile (
    .clk        (clk),
    .rst        (rst),
    .we_i       (wb_we_o),
    .wr_idx_i   (wb_rd_o),
    .wr_data_i  (wb_data_o),
    .rd1_idx_i  (d_rs1),
    .rd2_idx_i  (d_rs2),
    .rd1_data_o (rf_rd1),
    .rd2_data_o (rf_rd2)
  );

  rv_execute u_execute (
    .clk         (clk),
    .rst         (rst),
    .pc_i        (d_pc),
    .insn_i      (d_insn),
    .rs1_i       (d_rs1),
    .rs2_i       (d_rs2),
    .rd_i        (d_rd),
    .rs1_val_i   (d_rs1_val),
    .rs2_val_i   (d_rs2_val),
    .imm_i       (d_imm),
    .op_i        (d_op),
    .use_imm_i   (d_use_imm),
    .is_branch_i (d_is_branch),
    .funct3_i    (d_funct3),
    .status_i    (d_status),
    .mem_rd_i    (m_rd),
    .mem_we_i    (m_we),
    .mem_data_i  (m_data),
    .wb_rd_i     (wb_rd_o),
    .wb_we_i     (wb_we_o),
    .wb_data_i   (wb_data_o),
    .redirect_o  (e_redirect),
    .target_o    (e_target),
    .pc_o        (e_pc),
    .insn_o      (e_insn),
    .rd_o        (e_rd),
    .we_o        (e_we),
    .result_o    (e_result),
    .status_o    (e_status)
  );

  rv_retire u_retire (
    .clk         (clk),
    .rst         (rst),
    .ex_pc_i     (e_pc),
    .ex_insn_i   (e_insn),
    .ex_rd_i     (e_rd),
    .ex_we_i     (e_we),
    .ex_result_i (e_result),
    .ex_status_i (e_status),
    .mem_rd_o    (m_rd),
    .mem_we_o    (m_we),
    .mem_data_o  (m_data),
    .wb_pc_o     (wb_pc_o),
    .wb_insn_o   (wb_insn_o),
    .wb_status_o (wb_status_o),
    .wb_rd_o     (wb_rd_o),
    .wb_we_o     (wb_we_o),
    .wb_data_o   (wb_data_o)
  );

endmodule

/* src/rv_retire.sv */
module rv_retire (
  input  logic                       clk,
  input  logic                       rst,
  input  rv_isa_pkg::word_t          ex_pc_i,
  input  rv_isa_pkg::insn_t          ex_insn_i,
  input  rv_isa_pkg::reg_idx_t       ex_rd_i,
  input  logic                       ex_we_i,
  input  rv_isa_pkg::word_t          ex_result_i,
  input  rv_pipe_pkg::cycle_status_e ex_status_i,
  output rv_isa_pkg::reg_idx_t       mem_rd_o,
  output logic                       mem_we_o,
  output rv_isa_pkg::word_t          mem_data_o,
  output rv_isa_pkg::word_t          wb_pc_o,
  output rv_isa_pkg::insn_t          wb_insn_o,
  output rv_pipe_pkg::cycle_status_e wb_status_o,
  output rv_isa_pkg::reg_idx_t       wb_rd_o,
  output logic                       wb_we_o,
  output rv_isa_pkg::word_t          wb_data_o
);

  rv_isa_pkg::word_t          mem_pc;
  rv_isa_pkg::insn_t          mem_insn;
  rv_pipe_pkg::cycle_status_e mem_status;

  // Memory stage, then writeback
  always_ff @(posedge clk) begin
    if (rst) begin
      mem_pc      <= '0;
      mem_insn    <= '0;
      mem_we_o    <= 1'b0;
      mem_status  <= rv_pipe_pkg::RESET;
      wb_pc_o     <= '0;
      wb_insn_o   <= '0;
      wb_we_o     <= 1'b0;
      wb_status_o <= rv_pipe_pkg::RESET;
    end else begin
      mem_pc      <= ex_pc_i;
      mem_insn    <= ex_insn_i;
      mem_we_o    <= ex_we_i;
      mem_status  <= ex_status_i;
      wb_pc_o     <= mem_pc;
      wb_insn_o   <= mem_insn;
      wb_we_o     <= mem_we_o;
      wb_status_o <= mem_status;
    end
  end

  always_ff @(posedge clk) begin
    mem_rd_o   <= ex_rd_i;
    mem_data_o <= ex_result_i;
    wb_rd_o    <= mem_rd_o;
    wb_data_o  <= mem_data_o;
  end

  // Every stage tags its slot, so INVALID never reaches writeback
  a_status_valid: assert property (
    @(posedge clk) disable iff (rst) wb_status_o != rv_pipe_pkg::INVALID
  );

endmodule

/* src/rv_execute.sv */
module rv_execute (
  input  logic                       clk,
  input  logic                       rst,
  input  rv_isa_pkg::word_t          pc_i,
  input  rv_isa_pkg::insn_t          insn_i,
  input  rv_isa_pkg::reg_idx_t       rs1_i,
  input  rv_isa_pkg::reg_idx_t       rs2_i,
  input  rv_isa_pkg::reg_idx_t       rd_i,
  input  rv_isa_pkg::word_t          rs1_val_i,
  input  rv_isa_pkg::word_t          rs2_val_i,
  input  rv_isa_pkg::word_t          imm_i,
  input  rv_pipe_pkg::alu_op_e       op_i,
  input  logic                       use_imm_i,
  input  logic                       is_branch_i,
  input  rv_isa_pkg::funct3_t        funct3_i,
  input  rv_pipe_pkg::cycle_status_e status_i,
  input  rv_isa_pkg::reg_idx_t       mem_rd_i,
  input  logic                       mem_we_i,
  input  rv_isa_pkg::word_t          mem_data_i,
  input  rv_isa_pkg::reg_idx_t       wb_rd_i,
  input  logic                       wb_we_i,
  input  rv_isa_pkg::word_t          wb_data_i,
  output logic                       redirect_o,
  output rv_isa_pkg::word_t          target_o,
  output rv_isa_pkg::word_t          pc_o,
  output rv_isa_pkg::insn_t          insn_o,
  output rv_isa_pkg::reg_idx_t       rd_o,
  output logic                       we_o,
  output rv_isa_pkg::word_t          result_o,
  output rv_pipe_pkg::cycle_status_e status_o
);

  rv_isa_pkg::word_t          pc_q;
  rv_isa_pkg::insn_t          insn_q;
  rv_pipe_pkg::alu_op_e       op_q;
  logic                       is_branch_q;
  rv_pipe_pkg::cycle_status_e status_q;
  rv_isa_pkg::reg_idx_t       rs1_q;
  rv_isa_pkg::reg_idx_t       rs2_q;
  rv_isa_pkg::reg_idx_t       rd_q;
  rv_isa_pkg::word_t          rs1_val_q;
  rv_isa_pkg::word_t          rs2_val_q;
  rv_isa_pkg::word_t          imm_q;
  logic                       use_imm_q;
  rv_isa_pkg::funct3_t        funct3_q;
  rv_isa_pkg::word_t          op_a;
  rv_isa_pkg::word_t          rs2_fwd;
  logic                       taken;

  // Memory stage is younger, so it wins over writeback
  function automatic rv_isa_pkg::word_t bypass(rv_isa_pkg::reg_idx_t idx,
                                               rv_isa_pkg::word_t rf_val);
    if (mem_we_i && mem_rd_i == idx && idx != '0) begin
      return mem_data_i;
    end else if (wb_we_i && wb_rd_i == idx && idx != '0) begin
      return wb_data_i;
    end
    return rf_val;
  endfunction

  // A taken branch here turns the slot behind it into a bubble
  always_ff @(posedge clk) begin
    if (rst || redirect_o) begin
      pc_q        <= '0;
      insn_q      <= '0;
      op_q        <= rv_pipe_pkg::NONE;
      is_branch_q <= 1'b0;
      status_q    <= rst ? rv_pipe_pkg::RESET : rv_pipe_pkg::TAKEN_BRANCH;
    end else begin
      pc_q        <= pc_i;
      insn_q      <= insn_i;
      op_q        <= op_i;
      is_branch_q <= is_branch_i;
      status_q    <= status_i;
    end
  end

  always_ff @(posedge clk) begin
    rs1_q     <= rs1_i;
    rs2_q     <= rs2_i;
    rd_q      <= rd_i;
    rs1_val_q <= rs1_val_i;
    rs2_val_q <= rs2_val_i;
    imm_q     <= imm_i;
    use_imm_q <= use_imm_i;
    funct3_q  <= funct3_i;
  end

  always_comb begin
    op_a    = bypass(rs1_q, rs1_val_q);
    rs2_fwd = bypass(rs2_q, rs2_val_q);
  end

  rv_alu u_alu (
    .op_i     (op_q),
    .a_i      (op_a),
    .b_i      (use_imm_q ? imm_q : rs2_fwd),
    .funct3_i (funct3_q),
    .result_o (result_o),
    .taken_o  (taken)
  );

  assign redirect_o = is_branch_q && taken;
  assign target_o   = pc_q + imm_q;

  assign pc_o     = pc_q;
  assign insn_o   = insn_q;
  assign rd_o     = rd_q;
  assign status_o = status_q;
  // Writes to x0 are dropped here so nothing downstream sees them
  assign we_o = op_q != rv_pipe_pkg::NONE && !is_branch_q && rd_q != '0;

endmodule

/* src/rv_alu.sv */
module rv_alu (
  input  rv_pipe_pkg::alu_op_e op_i,
  input  rv_isa_pkg::word_t    a_i,
  input  rv_isa_pkg::word_t    b_i,
  input  rv_isa_pkg::funct3_t  funct3_i,
  output rv_isa_pkg::word_t    result_o,
  output logic                 taken_o
);

  logic              sub;
  rv_isa_pkg::word_t b_add;
  rv_isa_pkg::word_t sum;
  logic              lt_s;
  logic              lt_u;

  // Subtract is a plus the inverted b with a carry-in of one
  assign sub   = op_i == rv_pipe_pkg::SUB;
  assign b_add = sub ? ~b_i : b_i;
  assign sum   = a_i + b_add + rv_isa_pkg::word_t'(sub);

  assign lt_s = $signed(a_i) < $signed(b_i);
  assign lt_u = a_i < b_i;

  always_comb begin
    case (op_i)
      rv_pipe_pkg::ADD,
      rv_pipe_pkg::SUB:    result_o = sum;
      rv_pipe_pkg::SLL:    result_o = a_i << b_i[4:0];
      rv_pipe_pkg::SLT:    result_o = rv_isa_pkg::word_t'(lt_s);
      rv_pipe_pkg::SLTU:   result_o = rv_isa_pkg::word_t'(lt_u);
      rv_pipe_pkg::XOR:    result_o = a_i ^ b_i;
      rv_pipe_pkg::SRL:    result_o = a_i >> b_i[4:0];
      rv_pipe_pkg::SRA:    result_o = $signed(a_i) >>> b_i[4:0];
      rv_pipe_pkg::OR:     result_o = a_i | b_i;
      rv_pipe_pkg::AND:    result_o = a_i & b_i;
      rv_pipe_pkg::PASS_B: result_o = b_i;
      default:             result_o = '0;
    endcase
  end

  always_comb begin
    case (funct3_i)
      rv_isa_pkg::F3_BEQ:  taken_o = a_i == b_i;
      rv_isa_pkg::F3_BNE:  taken_o = a_i != b_i;
      rv_isa_pkg::F3_BLT:  taken_o = lt_s;
      rv_isa_pkg::F3_BGE:  taken_o = !lt_s;
      rv_isa_pkg::F3_BLTU: taken_o = lt_u;
      rv_isa_pkg::F3_BGEU: taken_o = !lt_u;
      default:             taken_o = 1'b0;
    endcase
  end

endmodule

/* src/rv_regfile.sv */
`include "rv_settings.svh"

module rv_regfile (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 we_i,
  input  rv_isa_pkg::reg_idx_t wr_idx_i,
  input  rv_isa_pkg::word_t    wr_data_i,
  input  rv_isa_pkg::reg_idx_t rd1_idx_i,
  input  rv_isa_pkg::reg_idx_t rd2_idx_i,
  output rv_isa_pkg::word_t    rd1_data_o,
  output rv_isa_pkg::word_t    rd2_data_o
);

  rv_isa_pkg::word_t regs [`RV_NUM_REGS];

  // x0 first, then a write landing this cycle, then the stored value
  function automatic rv_isa_pkg::word_t read_port(rv_isa_pkg::reg_idx_t idx);
    if (idx == '0) begin
      return '0;
    end else if (we_i && idx == wr_idx_i) begin
      return wr_data_i;
    end
    return regs[idx];
  endfunction

  always_comb begin
    rd1_data_o = read_port(rd1_idx_i);
    rd2_data_o = read_port(rd2_idx_i);
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `RV_NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we_i) begin
      regs[wr_idx_i] <= wr_data_i;
    end
  end

  // Execute never enables a write to x0
  a_no_x0_write: assert property (
    @(posedge clk) disable iff (rst) we_i |-> wr_idx_i != '0
  );

endmodule

/* src/rv_decode.sv */
module rv_decode (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       squash_i,
  input  rv_isa_pkg::word_t          pc_i,
  input  rv_isa_pkg::insn_t          insn_i,
  input  rv_isa_pkg::word_t          rs1_data_i,
  input  rv_isa_pkg::word_t          rs2_data_i,
  output rv_isa_pkg::word_t          pc_o,
  output rv_isa_pkg::insn_t          insn_o,
  output rv_isa_pkg::reg_idx_t       rs1_o,
  output rv_isa_pkg::reg_idx_t       rs2_o,
  output rv_isa_pkg::reg_idx_t       rd_o,
  output rv_isa_pkg::word_t          rs1_val_o,
  output rv_isa_pkg::word_t          rs2_val_o,
  output rv_isa_pkg::word_t          imm_o,
  output rv_pipe_pkg::alu_op_e       op_o,
  output logic                       use_imm_o,
  output logic                       is_branch_o,
  output rv_isa_pkg::funct3_t        funct3_o,
  output rv_pipe_pkg::cycle_status_e status_o
);

  rv_isa_pkg::opcode_e opcode;
  logic [6:0]          funct7;
  rv_isa_pkg::word_t   imm_i_type;
  rv_isa_pkg::word_t   imm_u_type;
  rv_isa_pkg::word_t   imm_b_type;

  // Op shared by OP and OP_IMM when funct7 is the base encoding
  function automatic rv_pipe_pkg::alu_op_e base_op(rv_isa_pkg::funct3_t f3);
    case (f3)
      rv_isa_pkg::F3_ADD:  return rv_pipe_pkg::ADD;
      rv_isa_pkg::F3_SLL:  return rv_pipe_pkg::SLL;
      rv_isa_pkg::F3_SLT:  return rv_pipe_pkg::SLT;
      rv_isa_pkg::F3_SLTU: return rv_pipe_pkg::SLTU;
      rv_isa_pkg::F3_XOR:  return rv_pipe_pkg::XOR;
      rv_isa_pkg::F3_SR:   return rv_pipe_pkg::SRL;
      rv_isa_pkg::F3_OR:   return rv_pipe_pkg::OR;
      default:             return rv_pipe_pkg::AND;
    endcase
  endfunction

  always_ff @(posedge clk) begin
    if (rst) begin
      pc_o     <= '0;
      insn_o   <= '0;
      status_o <= rv_pipe_pkg::RESET;
    end else if (squash_i) begin
      pc_o     <= '0;
      insn_o   <= '0;
      status_o <= rv_pipe_pkg::TAKEN_BRANCH;
    end else begin
      pc_o     <= pc_i;
      insn_o   <= insn_i;
      status_o <= rv_pipe_pkg::NO_STALL;
    end
  end

  assign opcode   = rv_isa_pkg::opcode_e'(insn_o[6:0]);
  assign funct3_o = insn_o[14:12];
  assign funct7   = insn_o[31:25];
  assign rd_o     = insn_o[11:7];
  assign rs1_o    = insn_o[19:15];
  assign rs2_o    = insn_o[24:20];

  // Register file reads come back in the same cycle
  assign rs1_val_o = rs1_data_i;
  assign rs2_val_o = rs2_data_i;

  // Sign-extended immediates
  assign imm_i_type = rv_isa_pkg::word_t'($signed(insn_o[31:20]));
  assign imm_u_type = rv_isa_pkg::word_t'($signed({insn_o[31:12], 12'b0}));
  assign imm_b_type = rv_isa_pkg::word_t'($signed({insn_o[31], insn_o[7], insn_o[30:25],
                                                    insn_o[11:8], 1'b0}));

  always_comb begin
    op_o        = rv_pipe_pkg::NONE;
    use_imm_o   = 1'b0;
    is_branch_o = 1'b0;
    imm_o       = imm_i_type;
    case (opcode)
      rv_isa_pkg::LUI: begin
        op_o      = rv_pipe_pkg::PASS_B;
        use_imm_o = 1'b1;
        imm_o     = imm_u_type;
      end
      rv_isa_pkg::OP_IMM: begin
        use_imm_o = 1'b1;
        op_o      = base_op(funct3_o);
        // Only the shifts check funct7, SRAI uses the alternate encoding
        if (funct3_o == rv_isa_pkg::F3_SR && funct7 == rv_isa_pkg::F7_ALT) begin
          op_o = rv_pipe_pkg::SRA;
        end else if ((funct3_o == rv_isa_pkg::F3_SLL || funct3_o == rv_isa_pkg::F3_SR) &&
                     funct7 != rv_isa_pkg::F7_BASE) begin
          op_o = rv_pipe_pkg::NONE;
        end
      end
      rv_isa_pkg::OP: begin
        if (funct7 == rv_isa_pkg::F7_BASE) begin
          op_o = base_op(funct3_o);
        end else if (funct7 == rv_isa_pkg::F7_ALT && funct3_o == rv_isa_pkg::F3_ADD) begin
          op_o = rv_pipe_pkg::SUB;
        end else if (funct7 == rv_isa_pkg::F7_ALT && funct3_o == rv_isa_pkg::F3_SR) begin
          op_o = rv_pipe_pkg::SRA;
        end
      end
      rv_isa_pkg::BRANCH: begin
        imm_o = imm_b_type;
        // funct3 010 and 011 are not branches
        is_branch_o = funct3_o != 3'b010 && funct3_o != 3'b011;
      end
      default: begin
      end
    endcase
  end

endmodule

/* src/rv_fetch.sv */
`include "rv_settings.svh"

module rv_fetch (
  input  logic              clk,
  input  logic              rst,
  input  logic              redirect_i,
  input  rv_isa_pkg::word_t target_i,
  output rv_isa_pkg::word_t pc_o
);

  always_ff @(posedge clk) begin
    if (rst) begin
      pc_o <= `RV_RESET_PC;
    end else if (redirect_i) begin
      pc_o <= target_i;
    end else begin
      pc_o <= pc_o + `RV_INSN_BYTES;
    end
  end

  // Branch targets from execute must keep the pc word-aligned
  a_pc_aligned: assert property (
    @(posedge clk) disable iff (rst) pc_o[1:0] == 2'b00
  );

endmodule

/* src/rv_pipe_pkg.sv */
package rv_pipe_pkg;

  // What occupies a slot as it passes writeback
  typedef enum logic [2:0] {
    INVALID      = 3'd0,
    RESET        = 3'd1,
    NO_STALL     = 3'd2,
    TAKEN_BRANCH = 3'd4
  } cycle_status_e;

  // ALU operations, NONE marks a slot that writes no register
  typedef enum logic [3:0] {
    ADD,
    SUB,
    SLL,
    SLT,
    SLTU,
    XOR,
    SRL,
    SRA,
    OR,
    AND,
    PASS_B,
    NONE
  } alu_op_e;

endpackage

/* src/rv_isa_pkg.sv */
`include "rv_settings.svh"

package rv_isa_pkg;

  typedef logic [`RV_XLEN-1:0] word_t;
  typedef logic [31:0] insn_t;
  typedef logic [4:0] reg_idx_t;
  typedef logic [2:0] funct3_t;

  // Base opcodes of RV32I
  typedef enum logic [6:0] {
    LOAD     = 7'b000_0011,
    MISC_MEM = 7'b000_1111,
    OP_IMM   = 7'b001_0011,
    AUIPC    = 7'b001_0111,
    STORE    = 7'b010_0011,
    OP       = 7'b011_0011,
    LUI      = 7'b011_0111,
    BRANCH   = 7'b110_0011,
    JALR     = 7'b110_0111,
    JAL      = 7'b110_1111,
    SYSTEM   = 7'b111_0011
  } opcode_e;

  // Branch conditions
  localparam funct3_t F3_BEQ  = 3'b000;
  localparam funct3_t F3_BNE  = 3'b001;
  localparam funct3_t F3_BLT  = 3'b100;
  localparam funct3_t F3_BGE  = 3'b101;
  localparam funct3_t F3_BLTU = 3'b110;
  localparam funct3_t F3_BGEU = 3'b111;

  // ALU group, shared by OP and OP_IMM
  localparam funct3_t F3_ADD  = 3'b000;
  localparam funct3_t F3_SLL  = 3'b001;
  localparam funct3_t F3_SLT  = 3'b010;
  localparam funct3_t F3_SLTU = 3'b011;
  localparam funct3_t F3_XOR  = 3'b100;
  localparam funct3_t F3_SR   = 3'b101;
  localparam funct3_t F3_OR   = 3'b110;
  localparam funct3_t F3_AND  = 3'b111;

  // funct7 selects SUB and SRA
  localparam logic [6:0] F7_BASE = 7'b000_0000;
  localparam logic [6:0] F7_ALT  = 7'b010_0000;

endpackage

/* src/rv_settings.svh */
`ifndef RV_SETTINGS_SVH
`define RV_SETTINGS_SVH

// Data path width
`define RV_XLEN 32

// Architectural integer registers
`define RV_NUM_REGS 32

// Address of the first fetch
`define RV_RESET_PC 32'h0000_0000

// PC step per instruction
`define RV_INSN_BYTES 4

`endif
